// File: common/bdPkg.sv
package bdPkg;

  // ------------------------------
  // Word field types
  // ------------------------------

  // Host command word and its fields
  typedef logic [31:0] hostWordT;
  typedef logic [6:0]  codeT;
  typedef logic [19:0] payloadT;

  // Register file
  typedef logic [15:0] regDataT;
  typedef logic [4:0]  regAddrT;

  // Chip side
  typedef logic [5:0]  leafT;
  typedef logic [5:0]  headerT;
  typedef logic [20:0] packetT;

  // Up to three 20-bit chunks
  typedef logic [59:0] wideT;

  // ------------------------------
  // Code ranges and registers
  // ------------------------------

  // Codes below this are leaves
  localparam codeT firstRegCode = 7'd64;
  // Codes from 64 up to here are register writes
  localparam codeT nopCode = 7'd96;

  // Bit 0 holds the chip reset
  localparam regAddrT resetReg = 5'd31;
  // Saturating drop count
  localparam regAddrT dropReg = 5'd30;

  // Leaves in the table
  localparam leafT adcLeaf  = 6'd0;
  localparam leafT dac0Leaf = 6'd1;
  localparam leafT amLeaf   = 6'd26;
  localparam leafT patLeaf  = 6'd27;

  // Serializer FSM
  typedef enum logic [1:0] {
    serIdle,
    serSend,
    serLast
  } serStateT;

  // ------------------------------
  // Leaf table lookup
  // ------------------------------

  // Returns 1 for a known leaf, fields through outputs
  function automatic logic bdLeafInfo(
    input  leafT       leaf,
    output headerT     header,
    output logic [1:0] chunks,
    output logic [5:0] totalBits,
    output logic [3:0] evenWidth,
    output logic [3:0] oddWidth
  );
    logic known;
    // Unknown leaf: harmless single-chunk defaults
    known     = 1'b1;
    header    = 6'b000000;
    chunks    = 2'd1;
    totalBits = 6'd0;
    evenWidth = 4'd0;
    oddWidth  = 4'd0;
    case (leaf)
      adcLeaf: begin
        header    = 6'b000001;
        totalBits = 6'd3;
        evenWidth = 4'd3;
        oddWidth  = 4'd3;
      end
      dac0Leaf: begin
        header    = 6'b000010;
        totalBits = 6'd11;
        evenWidth = 4'd11;
        oddWidth  = 4'd11;
      end
      amLeaf: begin
        header    = 6'b111001;
        chunks    = 2'd3;
        totalBits = 6'd42;
        evenWidth = 4'd11;
        oddWidth  = 4'd10;
      end
      patLeaf: begin
        header    = 6'b111010;
        chunks    = 2'd2;
        totalBits = 6'd40;
        evenWidth = 4'd10;
        oddWidth  = 4'd10;
      end
      default: known = 1'b0;
    endcase
    return known;
  endfunction

endpackage

// File: design/hostDecoder.sv
`timescale 1ns/10ps

module hostDecoder (
  input  logic            sysClk,
  input  logic            rst,
  input  bdPkg::hostWordT hostWord,
  input  logic            hostValid,
  input  logic            chipReset,
  output logic            regWe,
  output bdPkg::regAddrT  regWAddr,
  output bdPkg::regDataT  regWData,
  output logic            chunkValid,
  output bdPkg::leafT     chunkLeaf,
  output bdPkg::payloadT  chunkData,
  output logic            dropPulse
);

  // Fields of the incoming word
  bdPkg::codeT    code;
  bdPkg::payloadT payload;
  logic           topBad;
  logic           isLeaf;
  logic           isReg;

  // Leaf lookup, only known is needed here
  logic           leafKnown;
  bdPkg::headerT  leafHeader;
  logic [1:0]     leafChunks;
  logic [5:0]     leafBits;
  logic [3:0]     leafEven;
  logic [3:0]     leafOdd;

  // ------------------------------
  // Classify
  // ------------------------------
  always_comb begin
    code    = hostWord[26:20];
    payload = hostWord[19:0];
    // Reserved top bits must be zero
    topBad  = |hostWord[31:27];
    isLeaf  = code < bdPkg::firstRegCode;
    isReg   = (code >= bdPkg::firstRegCode) && (code < bdPkg::nopCode);
    leafKnown = bdPkg::bdLeafInfo(code[5:0], leafHeader, leafChunks, leafBits,
                                  leafEven, leafOdd);
  end

  // Strobes, one cycle after hostValid
  always_ff @(posedge sysClk) begin
    if (rst) begin
      regWe      <= 1'b0;
      chunkValid <= 1'b0;
      dropPulse  <= 1'b0;
    end else begin
      regWe      <= hostValid && !topBad && isReg;
      chunkValid <= hostValid && !topBad && isLeaf && leafKnown && !chipReset;
      // Leaf held in reset, unknown leaf or bad top bits
      dropPulse  <= hostValid && (topBad || (isLeaf && (chipReset || !leafKnown)));
    end
  end

  // Payload side, captured on every strobe
  always_ff @(posedge sysClk) begin
    if (hostValid) begin
      // code - 64 is just the low bits
      regWAddr  <= code[4:0];
      regWData  <= payload[15:0];
      chunkLeaf <= code[5:0];
      chunkData <= payload;
    end
  end

  // Host leaves a gap so a registered word is taken before the next
  assert property (@(posedge sysClk) disable iff (rst) hostValid |=> !hostValid)
    else $error("hostValid while previous word pending");

endmodule

// File: design/regBank.sv
`timescale 1ns/10ps

module regBank #(
  parameter int numRegs = 32
) (
  input  logic           sysClk,
  input  logic           rst,
  input  logic           regWe,
  input  bdPkg::regAddrT regWAddr,
  input  bdPkg::regDataT regWData,
  input  logic           dropPulse,
  input  bdPkg::regAddrT regAddr,
  output bdPkg::regDataT regData,
  output logic           chipReset
);

  // Control registers
  bdPkg::regDataT regs [numRegs];

  // ------------------------------
  // Writes and drop counter
  // ------------------------------
  always_ff @(posedge sysClk) begin
    if (rst) begin
      // Chip held in reset until the host clears it
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= (i == int'(bdPkg::resetReg)) ? bdPkg::regDataT'(1) : '0;
      end
    end else begin
      // Drop register is read only from the host side
      if (regWe && (regWAddr != bdPkg::dropReg) && (int'(regWAddr) < numRegs)) begin
        regs[regWAddr] <= regWData;
      end
      // Saturates at all ones
      if (dropPulse && (regs[bdPkg::dropReg] != '1)) begin
        regs[bdPkg::dropReg] <= regs[bdPkg::dropReg] + 1'b1;
      end
    end
  end

  // ------------------------------
  // Readback
  // ------------------------------

  // Out of range reads as zero
  assign regData = (int'(regAddr) < numRegs) ? regs[regAddr] : '0;

  assign chipReset = regs[bdPkg::resetReg][0];

endmodule

// File: bdPack/wordAssembler.sv
`timescale 1ns/10ps

module wordAssembler (
  input  logic           sysClk,
  input  logic           rst,
  input  logic           chunkValid,
  input  bdPkg::leafT    chunkLeaf,
  input  bdPkg::payloadT chunkData,
  input  logic           serBusy,
  output logic           hostReady,
  output logic           wideValid,
  output bdPkg::wideT    wideData,
  output bdPkg::leafT    wideLeaf
);

  // Chunks taken so far for the current word
  logic [1:0]    chunkCnt;
  logic          lastChunk;

  // Leaf lookup
  logic          leafKnown;
  bdPkg::headerT leafHeader;
  logic [1:0]    leafChunks;
  logic [5:0]    leafBits;
  logic [3:0]    leafEven;
  logic [3:0]    leafOdd;

  always_comb begin
    leafKnown = bdPkg::bdLeafInfo(chunkLeaf, leafHeader, leafChunks, leafBits,
                                  leafEven, leafOdd);
    // Unknown leaf closes at once
    lastChunk = !leafKnown || ((chunkCnt + 2'd1) >= leafChunks);
  end

  // ------------------------------
  // Chunk count
  // ------------------------------
  always_ff @(posedge sysClk) begin
    if (rst) begin
      chunkCnt  <= 2'd0;
      wideValid <= 1'b0;
    end else begin
      // One-cycle pulse after the final chunk
      wideValid <= chunkValid && lastChunk;
      if (chunkValid) begin
        chunkCnt <= lastChunk ? 2'd0 : chunkCnt + 2'd1;
      end
    end
  end

  // ------------------------------
  // Word assembly
  // ------------------------------

  // Chunk n lands at bit 20n
  always_ff @(posedge sysClk) begin
    if (chunkValid) begin
      wideLeaf <= chunkLeaf;
      case (chunkCnt)
        2'd1:    wideData[39:20] <= chunkData;
        2'd2:    wideData[59:40] <= chunkData;
        // First chunk clears the upper part
        default: wideData <= bdPkg::wideT'(chunkData);
      endcase
    end
  end

  // Low from the finished word until the last packet is out
  assign hostReady = !(wideValid || serBusy);

  // Chunks of one word come from one leaf
  assert property (@(posedge sysClk) disable iff (rst)
    chunkValid && (chunkCnt != 2'd0) |-> chunkLeaf == wideLeaf)
    else $error("Leaf changed inside a word");

endmodule

// File: bdPack/packetSerializer.sv
`timescale 1ns/10ps

module packetSerializer (
  input  logic          sysClk,
  input  logic          rst,
  input  logic          wideValid,
  input  bdPkg::wideT   wideData,
  input  bdPkg::leafT   wideLeaf,
  output bdPkg::packetT outData,
  output logic          outValid,
  input  logic          outReady,
  output logic          serBusy
);

  bdPkg::serStateT state;

  // Latched word, shifted down after each packet
  bdPkg::wideT   shiftReg;
  bdPkg::leafT   curLeaf;
  logic [5:0]    consumed;
  logic          oddPkt;

  // Leaf lookup
  bdPkg::leafT   infoLeaf;
  logic          leafKnown;
  bdPkg::headerT leafHeader;
  logic [1:0]    leafChunks;
  logic [5:0]    leafBits;
  logic [3:0]    evenWidth;
  logic [3:0]    oddWidth;

  // Slice of the current packet
  logic [3:0]    curWidth;
  logic [3:0]    nextWidth;
  logic [3:0]    sliceWidth;
  logic [5:0]    remaining;
  logic [14:0]   sliceMask;
  logic          xfer;

  // ------------------------------
  // Slice select
  // ------------------------------
  always_comb begin
    // Look at the incoming leaf while idle
    infoLeaf  = (state == bdPkg::serIdle) ? wideLeaf : curLeaf;
    leafKnown = bdPkg::bdLeafInfo(infoLeaf, leafHeader, leafChunks, leafBits,
                                  evenWidth, oddWidth);
    curWidth  = oddPkt ? oddWidth : evenWidth;
    nextWidth = oddPkt ? evenWidth : oddWidth;
    remaining = leafBits - consumed;
    // Trim the final slice to what is left
    sliceWidth = (remaining < 6'(curWidth)) ? remaining[3:0] : curWidth;
    sliceMask  = 15'((16'd1 << sliceWidth) - 16'd1);
  end

  assign outValid = (state != bdPkg::serIdle);
  assign serBusy  = outValid;
  assign xfer     = outValid && outReady;

  // Header low, zero-extended slice above
  assign outData = {shiftReg[14:0] & sliceMask, leafHeader};

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge sysClk) begin
    if (rst) begin
      state <= bdPkg::serIdle;
    end else begin
      case (state)
        bdPkg::serIdle: begin
          // Unknown leaf is discarded
          if (wideValid && leafKnown) begin
            state <= (6'(evenWidth) >= leafBits) ? bdPkg::serLast : bdPkg::serSend;
          end
        end
        bdPkg::serSend: begin
          // Next packet is the last one when it reaches totalBits
          if (xfer && ((consumed + 6'(sliceWidth) + 6'(nextWidth)) >= leafBits)) begin
            state <= bdPkg::serLast;
          end
        end
        bdPkg::serLast: begin
          if (xfer) begin
            state <= bdPkg::serIdle;
          end
        end
        default: state <= bdPkg::serIdle;
      endcase
    end
  end

  // Datapath, loaded on start and stepped per transfer
  always_ff @(posedge sysClk) begin
    if (state == bdPkg::serIdle) begin
      if (wideValid) begin
        shiftReg <= wideData;
        curLeaf  <= wideLeaf;
        consumed <= 6'd0;
        oddPkt   <= 1'b0;
      end
    end else if (xfer) begin
      shiftReg <= shiftReg >> sliceWidth;
      consumed <= consumed + 6'(sliceWidth);
      oddPkt   <= !oddPkt;
    end
  end

  // Held packet under back-pressure
  assert property (@(posedge sysClk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outData))
    else $error("outData changed while stalled");

  // hostReady upstream keeps new words out while busy
  assert property (@(posedge sysClk) disable iff (rst) wideValid |-> !serBusy)
    else $error("wideValid while serializer busy");

endmodule

// File: design/bdCore.sv
`timescale 1ns/10ps

module bdCore #(
  parameter int numRegs = 32
) (
  input  logic            sysClk,
  input  logic            rst,
  // Host side
  input  bdPkg::hostWordT hostWord,
  input  logic            hostValid,
  output logic            hostReady,
  // Chip side
  output bdPkg::packetT   outData,
  output logic            outValid,
  input  logic            outReady,
  // Control and readback
  output logic            chipReset,
  input  bdPkg::regAddrT  regAddr,
  output bdPkg::regDataT  regData
);

  // ------------------------------
  // Internal wiring
  // ------------------------------

  // Register write port
  logic           regWe;
  bdPkg::regAddrT regWAddr;
  bdPkg::regDataT regWData;
  logic           dropPulse;

  // Leaf chunks
  logic           chunkValid;
  bdPkg::leafT    chunkLeaf;
  bdPkg::payloadT chunkData;

  // Wide word to the serializer
  logic           wideValid;
  bdPkg::wideT    wideData;
  bdPkg::leafT    wideLeaf;
  logic           serBusy;

  hostDecoder uDecoder (
    .sysClk     (sysClk),
    .rst        (rst),
    .hostWord   (hostWord),
    .hostValid  (hostValid),
    .chipReset  (chipReset),
    .regWe      (regWe),
    .regWAddr   (regWAddr),
    .regWData   (regWData),
    .chunkValid (chunkValid),
    .chunkLeaf  (chunkLeaf),
    .chunkData  (chunkData),
    .dropPulse  (dropPulse)
  );

  regBank #(
    .numRegs (numRegs)
  ) uRegs (
    .sysClk    (sysClk),
    .rst       (rst),
    .regWe     (regWe),
    .regWAddr  (regWAddr),
    .regWData  (regWData),
    .dropPulse (dropPulse),
    .regAddr   (regAddr),
    .regData   (regData),
    .chipReset (chipReset)
  );

  // Leaf path
  wordAssembler uAssembler (
    .sysClk     (sysClk),
    .rst        (rst),
    .chunkValid (chunkValid),
    .chunkLeaf  (chunkLeaf),
    .chunkData  (chunkData),
    .serBusy    (serBusy),
    .hostReady  (hostReady),
    .wideValid  (wideValid),
    .wideData   (wideData),
    .wideLeaf   (wideLeaf)
  );

  packetSerializer uSerializer (
    .sysClk    (sysClk),
    .rst       (rst),
    .wideValid (wideValid),
    .wideData  (wideData),
    .wideLeaf  (wideLeaf),
    .outData   (outData),
    .outValid  (outValid),
    .outReady  (outReady),
    .serBusy   (serBusy)
  );

endmodule

// File: verif/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic sysClk,
  output logic rst
);

  // 4 ns period
  initial begin
    sysClk = 1'b0;
    forever #2 sysClk = ~sysClk;
  end

  // Reset over four rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge sysClk);
    @(negedge sysClk);
    rst = 1'b0;
  end

endmodule

// File: verif/bdCore_tb.sv
`timescale 1ns/10ps

module bdCore_tb;

  // Well above the few hundred cycles the tests need
  localparam int timeoutCycles = 4000;

  logic        sysClk;
  logic        rst;
  logic [31:0] hostWord;
  logic        hostValid;
  logic        hostReady;
  logic [20:0] outData;
  logic        outValid;
  logic        outReady;
  logic        chipReset;
  logic [4:0]  regAddr;
  logic [15:0] regData;

  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  // Packets the model expects for the current leaf word
  logic [20:0] expQ[$];

  clockGen uClock (.sysClk(sysClk), .rst(rst));

  bdCore #(.numRegs(32)) DUT (
    .sysClk(sysClk), .rst(rst),
    .hostWord(hostWord), .hostValid(hostValid), .hostReady(hostReady),
    .outData(outData), .outValid(outValid), .outReady(outReady),
    .chipReset(chipReset), .regAddr(regAddr), .regData(regData)
  );

  // ------------------------------
  // Checking and reference model
  // ------------------------------
  task automatic checkValue(input string what, input logic [63:0] actual,
                            input logic [63:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Leaf table with header, chunks, bits and slice widths
  function automatic void leafSpec(input logic [5:0] leaf, output logic [5:0] header,
                                   output int chunks, output int bits,
                                   output int evenW, output int oddW);
    header = 6'b000000;
    chunks = 1;
    bits   = 0;
    evenW  = 0;
    oddW   = 0;
    case (leaf)
      6'd0: begin
        header = 6'b000001;
        bits   = 3;
        evenW  = 3;
        oddW   = 3;
      end
      6'd1: begin
        header = 6'b000010;
        bits   = 11;
        evenW  = 11;
        oddW   = 11;
      end
      6'd26: begin
        header = 6'b111001;
        chunks = 3;
        bits   = 42;
        evenW  = 11;
        oddW   = 10;
      end
      6'd27: begin
        header = 6'b111010;
        chunks = 2;
        bits   = 40;
        evenW  = 10;
        oddW   = 10;
      end
      default: ;
    endcase
  endfunction

  // Cut a leaf value into expected packets with the last slice trimmed
  task automatic buildExpected(input logic [5:0] leaf, input logic [59:0] value);
    logic [5:0]  header;
    logic [59:0] rest;
    logic [14:0] slice;
    int          chunks, bits, evenW, oddW, used, w, idx;
    leafSpec(leaf, header, chunks, bits, evenW, oddW);
    expQ.delete();
    rest = value;
    used = 0;
    idx  = 0;
    while (used < bits) begin
      w = (idx % 2) ? oddW : evenW;
      if (bits - used < w) w = bits - used;
      slice = 15'(rest & ((60'd1 << w) - 60'd1));
      expQ.push_back({slice, header});
      rest = rest >> w;
      used += w;
      idx++;
    end
  endtask

  // ------------------------------
  // Host and chip side drivers
  // ------------------------------

  // Strobe one word and idle until hostReady reflects it
  task automatic sendWord(input logic [31:0] word);
    while (!hostReady) @(negedge sysClk);
    hostWord  = word;
    hostValid = 1'b1;
    @(negedge sysClk);
    hostValid = 1'b0;
    repeat (2) @(negedge sysClk);
  endtask

  function automatic logic [31:0] leafWord(input logic [5:0] leaf, input logic [19:0] data);
    return {5'd0, 1'b0, leaf, data};
  endfunction

  task automatic regWrite(input logic [4:0] addr, input logic [15:0] data);
    sendWord({5'd0, 7'(7'd64 + addr), 4'd0, data});
  endtask

  // Chunk n comes from bits 20n and up
  task automatic sendLeaf(input logic [5:0] leaf, input logic [59:0] value);
    logic [5:0] header;
    int         chunks, bits, evenW, oddW;
    leafSpec(leaf, header, chunks, bits, evenW, oddW);
    for (int i = 0; i < chunks; i++) begin
      sendWord(leafWord(leaf, value[i*20 +: 20]));
    end
  endtask

  task automatic readReg(input logic [4:0] addr, input logic [15:0] expected);
    regAddr = addr;
    @(negedge sysClk);
    checkValue($sformatf("register %0d", addr), regData, expected);
  endtask

  task automatic expectIdle(input int cycles);
    repeat (cycles) begin
      @(negedge sysClk);
      checkValue("outValid while idle", outValid, 0);
    end
  endtask

  // A packet is taken where valid and random outReady meet
  task automatic collectPackets();
    int got;
    got = 0;
    while (got < expQ.size()) begin
      outReady = ($urandom % 4) != 0;
      if (outValid && outReady) begin
        checkValue($sformatf("packet %0d", got), outData, expQ[got]);
        got++;
      end
      @(negedge sysClk);
    end
    outReady = 1'b0;
    checkValue("outValid after last packet", outValid, 0);
    checkValue("hostReady after last packet", hostReady, 1);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic checkResetState();
    checkValue("outValid after reset", outValid, 0);
    checkValue("hostReady after reset", hostReady, 1);
    checkValue("chipReset after reset", chipReset, 1);
    readReg(31, 16'd1);
    readReg(30, 16'd0);
  endtask

  // ADC word while the chip is held in reset
  task automatic checkResetDrop();
    sendLeaf(6'd0, 60'($urandom));
    expectIdle(6);
    readReg(30, 16'd1);
  endtask

  task automatic checkRegisters();
    logic [15:0] d5, d12;
    d5  = 16'($urandom);
    d12 = 16'($urandom);
    regWrite(5, d5);
    regWrite(12, d12);
    readReg(5, d5);
    readReg(12, d12);
    regWrite(31, 16'd0);
    checkValue("chipReset after clear", chipReset, 0);
    readReg(31, 16'd0);
    // No-op with a full payload
    sendWord({5'd0, 7'd96, 20'hFFFFF});
    expectIdle(6);
    // Code 96 would land on register 0 if taken as a write
    readReg(0, 16'd0);
    readReg(5, d5);
    readReg(12, d12);
    readReg(30, 16'd1);
    readReg(31, 16'd0);
  endtask

  task automatic checkUnknownLeaf();
    sendWord(leafWord(6'd40, 20'($urandom)));
    expectIdle(6);
    readReg(30, 16'd2);
  endtask

  task automatic checkAmWord();
    logic [59:0] value;
    value = 60'(42'h2D3C5A96E1B);
    buildExpected(6'd26, value);
    checkValue("AM packet count", expQ.size(), 4);
    sendLeaf(6'd26, value);
    collectPackets();
  endtask

  task automatic checkShortLeaves();
    logic [59:0] value;
    value = 60'({$urandom, $urandom});
    buildExpected(6'd0, value);
    checkValue("ADC packet count", expQ.size(), 1);
    sendLeaf(6'd0, value);
    collectPackets();
    value = 60'({$urandom, $urandom});
    buildExpected(6'd1, value);
    checkValue("DAC0 packet count", expQ.size(), 1);
    sendLeaf(6'd1, value);
    collectPackets();
    value = 60'({$urandom, $urandom});
    buildExpected(6'd27, value);
    checkValue("PAT packet count", expQ.size(), 4);
    sendLeaf(6'd27, value);
    collectPackets();
  endtask

  // First packet held for 20 cycles with outReady low
  task automatic checkBackPressure();
    logic [59:0] value;
    value = 60'({$urandom, $urandom});
    buildExpected(6'd27, value);
    sendLeaf(6'd27, value);
    @(negedge sysClk);
    checkValue("outValid before stall", outValid, 1);
    checkValue("outData before stall", outData, expQ[0]);
    repeat (20) begin
      @(negedge sysClk);
      checkValue("outValid during stall", outValid, 1);
      checkValue("outData during stall", outData, expQ[0]);
      checkValue("hostReady during stall", hostReady, 0);
    end
    collectPackets();
  endtask

  // ------------------------------
  // Run control
  // ------------------------------
  always @(posedge sysClk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount == timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    hostWord  = '0;
    hostValid = 1'b0;
    outReady  = 1'b0;
    regAddr   = '0;
    void'($urandom(66));
    @(negedge sysClk);
    while (rst) @(negedge sysClk);
    @(negedge sysClk);
    checkResetState();
    checkResetDrop();
    checkRegisters();
    checkUnknownLeaf();
    checkAmWord();
    checkShortLeaves();
    checkBackPressure();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: bdCore.f
common/bdPkg.sv
design/hostDecoder.sv
design/regBank.sv
bdPack/wordAssembler.sv
bdPack/packetSerializer.sv
design/bdCore.sv
verif/clockGen.sv
verif/bdCore_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = bdCore_tb
FILELIST  = bdCore.f
OBJDIR    = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
